// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal -j 0
TOP       := requant_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/credit_fifo.sv
module credit_fifo #(
    parameter int IN_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  num_fmt_pkg::acc_word_u push_word,
    input  requant_pkg::chan_t     push_chan,
    input  logic                   pop,
    output num_fmt_pkg::acc_word_u head_word,
    output requant_pkg::chan_t     head_chan,
    output logic                   not_empty,
    output logic                   credit
);
    import num_fmt_pkg::*;
    import requant_pkg::*;

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    acc_word_u        word_mem [IN_DEPTH];
    chan_t            chan_mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wraps at IN_DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
        if (p == PTR_W'(IN_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign head_word = word_mem[rd_ptr];
    assign head_chan = chan_mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            count  <= count + CNT_W'(push) - CNT_W'(pop);
            credit <= pop;  // slot freed, hand it back to the source
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            word_mem[wr_ptr] <= push_word;
            chan_mem[wr_ptr] <= push_chan;
        end
    end

endmodule

// File: design/mult_arbiter.sv
module mult_arbiter (
    input  logic                     clk,
    input  logic                     reset,
    mult_port_if.arb                 lanes [requant_pkg::NUM_LANES],
    input  num_fmt_pkg::tail_t [1:0] tail_in [requant_pkg::NUM_LANES],
    mult_port_if.lane                shared,
    output num_fmt_pkg::tail_t [1:0] tail_pair
);
    import num_fmt_pkg::*;
    import requant_pkg::*;

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0] req_vec;
    sum_t [1:0]           a_vec [NUM_LANES];
    logic [IDX_W-1:0]     prio;      // first lane looked at
    logic [IDX_W-1:0]     sel;
    logic [IDX_W-1:0]     resp_sel;  // lane owed the product in flight
    logic                 found;

    function automatic logic [IDX_W-1:0] rr_idx(logic [IDX_W-1:0] base, int offs);
        return IDX_W'((int'(base) + offs) % NUM_LANES);
    endfunction

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        assign req_vec[i] = lanes[i].req;
        assign a_vec[i] = lanes[i].a_pair;
        assign lanes[i].gnt = shared.gnt && (sel == IDX_W'(i));
        assign lanes[i].p_valid = shared.p_valid && (resp_sel == IDX_W'(i));
        assign lanes[i].p_pair = shared.p_pair;
    end

    always_comb begin
        sel = prio;
        found = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (!found && req_vec[rr_idx(prio, k)]) begin
                sel = rr_idx(prio, k);
                found = 1'b1;
            end
        end
    end

    assign shared.req = found;
    assign shared.a_pair = a_vec[sel];
    assign tail_pair = tail_in[sel];  // B side travels beside the port

    always_ff @(posedge clk) begin
        if (reset) begin
            prio     <= '0;
            resp_sel <= '0;
        end else if (shared.gnt) begin
            prio     <= rr_idx(sel, 1);  // winner goes to the back
            resp_sel <= sel;
        end
    end

endmodule

// File: design/mult_port_if.sv
interface mult_port_if;
    import num_fmt_pkg::*;

    logic        req;
    sum_t  [1:0] a_pair;  // A operands, held until gnt
    logic        gnt;
    logic        p_valid; // one cycle after gnt
    prod_t [1:0] p_pair;

    modport lane (
        output req, a_pair,
        input  gnt, p_valid, p_pair
    );

    modport arb (
        input  req, a_pair,
        output gnt, p_valid, p_pair
    );

endinterface

// File: design/num_fmt_pkg.sv
package num_fmt_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // accumulator word, one wide sum or two narrow ones
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic signed [15:0] hi;  // channel ch+1
        logic signed [15:0] lo;  // channel ch
    } half_pair_t;

    typedef union packed {
        logic signed [31:0] full;  // mode_88
        half_pair_t         half;  // mode_18
    } acc_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // multiplier operands and results
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [23:0] sum_t;   // after bias add, A side
    typedef logic        [15:0] tail_t;  // scale tail, B side
    typedef logic signed [39:0] prod_t;
    typedef logic signed [7:0]  q8_t;

    typedef struct packed {
        q8_t b1;
        q8_t b0;
    } out_word_t;

endpackage

// File: design/requant_lane.sv
module requant_lane #(
    parameter int OUT_CREDITS = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  requant_pkg::mode_e       mode,
    input  num_fmt_pkg::acc_word_u   head_word,
    input  requant_pkg::chan_t       head_chan,
    input  logic                     not_empty,
    output logic                     pop,
    output requant_pkg::chan_t       coef_chan,
    input  requant_pkg::coef_t [1:0] coef_pair,
    mult_port_if.lane                mult,
    output num_fmt_pkg::tail_t [1:0] tail_pair,
    output logic                     out_valid,
    output num_fmt_pkg::out_word_t   out_data,
    input  logic                     out_credit
);
    import num_fmt_pkg::*;
    import requant_pkg::*;

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic               bias_valid;
    sum_t  [1:0]        bias_sum;
    tail_t [1:0]        bias_tail;
    logic  [1:0][4:0]   bias_rank;
    sum_t  [1:0]        sum_nxt;
    logic signed [31:0] ext_bias0;
    logic signed [31:0] ext_bias1;

    logic               mul_valid;  // product owed by the multiplier
    logic  [1:0][4:0]   mul_rank;

    logic               res_valid;
    out_word_t          res_word;
    logic [CRED_W-1:0]  credits;
    logic               res_fire;
    logic               issue_ok;

    // round half up, arithmetic shift, clamp to q8
    function automatic q8_t round_sat(prod_t p, logic [4:0] rank);
        logic signed [40:0] acc;
        logic signed [40:0] rnd;
        acc = p;
        if (rank != '0) begin
            rnd = 41'sd1 <<< (rank - 5'd1);
            acc = (acc + rnd) >>> rank;
        end
        if (acc > 41'sd127) return 8'sd127;
        if (acc < -41'sd128) return -8'sd128;
        return q8_t'(acc);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bias stage
    ////////////////////////////////////////////////////////////////////////////

    assign coef_chan = head_chan;  // coefficients follow the fifo head
    assign ext_bias0 = 32'(coef_pair[0].bias);
    assign ext_bias1 = 32'(coef_pair[1].bias);

    always_comb begin
        if (mode == mode_18) begin
            sum_nxt[0] = sum_t'(32'(head_word.half.lo) + ext_bias0);
            sum_nxt[1] = sum_t'(32'(head_word.half.hi) + ext_bias1);
        end else begin
            sum_nxt[0] = sum_t'(head_word.full + ext_bias0);
            sum_nxt[1] = '0;  // upper byte comes out as zero
        end
    end

    assign pop = not_empty && (!bias_valid || mult.gnt);

    ////////////////////////////////////////////////////////////////////////////
    // multiplier request and output stage
    ////////////////////////////////////////////////////////////////////////////

    assign res_fire = res_valid && (credits != '0);
    assign out_valid = res_fire;
    assign out_data = res_word;

    // products cannot stall, so only issue when the output slot is free next cycle
    assign issue_ok = !mul_valid && (!res_valid || res_fire);
    assign mult.req = bias_valid && issue_ok;
    assign mult.a_pair = bias_sum;
    assign tail_pair = bias_tail;

    always_ff @(posedge clk) begin
        if (reset) begin
            bias_valid <= 1'b0;
            mul_valid  <= 1'b0;
            res_valid  <= 1'b0;
            credits    <= CRED_W'(OUT_CREDITS);
        end else begin
            if (pop) bias_valid <= 1'b1;
            else if (mult.gnt) bias_valid <= 1'b0;
            if (mult.gnt) mul_valid <= 1'b1;
            else if (mult.p_valid) mul_valid <= 1'b0;
            if (mult.p_valid) res_valid <= 1'b1;
            else if (res_fire) res_valid <= 1'b0;
            credits <= credits + CRED_W'(out_credit) - CRED_W'(res_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            bias_sum     <= sum_nxt;
            bias_tail[0] <= coef_pair[0].tail;
            bias_tail[1] <= coef_pair[1].tail;
            bias_rank[0] <= coef_pair[0].rank;
            bias_rank[1] <= coef_pair[1].rank;
        end
        if (mult.gnt) mul_rank <= bias_rank;
        if (mult.p_valid) begin
            res_word.b0 <= round_sat(mult.p_pair[0], mul_rank[0]);
            res_word.b1 <= round_sat(mult.p_pair[1], mul_rank[1]);
        end
    end

endmodule

// File: design/requant_pkg.sv
package requant_pkg;

    typedef enum logic {
        mode_88 = 1'b0,  // one wide sum per word
        mode_18 = 1'b1   // two 16 bit sums, ch and ch+1
    } mode_e;

    typedef logic [3:0] chan_t;

    localparam int NUM_CHANNELS = 16;
    localparam int NUM_LANES    = 2;

    // per channel requant coefficients
    typedef struct packed {
        logic signed [7:0]  bias;
        num_fmt_pkg::tail_t tail;
        logic        [4:0]  rank;  // right shift amount
    } coef_t;

endpackage

// File: design/requant_top.sv
module requant_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  requant_pkg::mode_e                                    mode,
    input  logic                                                  coef_we,
    input  requant_pkg::chan_t                                    coef_addr,
    input  requant_pkg::coef_t                                    coef_wdata,
    input  logic [requant_pkg::NUM_LANES-1:0]                     in_valid,
    input  num_fmt_pkg::acc_word_u [requant_pkg::NUM_LANES-1:0]   in_word,
    input  requant_pkg::chan_t [requant_pkg::NUM_LANES-1:0]       in_chan,
    output logic [requant_pkg::NUM_LANES-1:0]                     in_credit,
    output logic [requant_pkg::NUM_LANES-1:0]                     out_valid,
    output num_fmt_pkg::out_word_t [requant_pkg::NUM_LANES-1:0]   out_data,
    input  logic [requant_pkg::NUM_LANES-1:0]                     out_credit
);
    import num_fmt_pkg::*;
    import requant_pkg::*;

    acc_word_u        head_word [NUM_LANES];
    chan_t            head_chan [NUM_LANES];
    logic             not_empty [NUM_LANES];
    logic             pop       [NUM_LANES];
    chan_t            coef_chan [NUM_LANES];
    coef_t [1:0]      coef_pair [NUM_LANES];
    tail_t [1:0]      lane_tail [NUM_LANES];
    tail_t [1:0]      mult_tail;

    mult_port_if lane_mp [NUM_LANES] ();
    mult_port_if shared_mp ();

    ////////////////////////////////////////////////////////////////////////////
    // per lane input buffer and requant pipeline
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        credit_fifo #(
            .IN_DEPTH(IN_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .reset    (reset),
            .push     (in_valid[i]),
            .push_word(in_word[i]),
            .push_chan(in_chan[i]),
            .pop      (pop[i]),
            .head_word(head_word[i]),
            .head_chan(head_chan[i]),
            .not_empty(not_empty[i]),
            .credit   (in_credit[i])
        );

        requant_lane #(
            .OUT_CREDITS(OUT_CREDITS)
        ) u_lane (
            .clk       (clk),
            .reset     (reset),
            .mode      (mode),
            .head_word (head_word[i]),
            .head_chan (head_chan[i]),
            .not_empty (not_empty[i]),
            .pop       (pop[i]),
            .coef_chan (coef_chan[i]),
            .coef_pair (coef_pair[i]),
            .mult      (lane_mp[i]),
            .tail_pair (lane_tail[i]),
            .out_valid (out_valid[i]),
            .out_data  (out_data[i]),
            .out_credit(out_credit[i])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // shared resources
    ////////////////////////////////////////////////////////////////////////////

    scale_coef_regs u_coef (
        .clk       (clk),
        .reset     (reset),
        .coef_we   (coef_we),
        .coef_addr (coef_addr),
        .coef_wdata(coef_wdata),
        .rd_chan   (coef_chan),
        .rd_pair   (coef_pair)
    );

    mult_arbiter u_arb (
        .clk      (clk),
        .reset    (reset),
        .lanes    (lane_mp),
        .tail_in  (lane_tail),
        .shared   (shared_mp),
        .tail_pair(mult_tail)
    );

    scale_mult_array u_mult (
        .clk      (clk),
        .reset    (reset),
        .port     (shared_mp),
        .tail_pair(mult_tail)
    );

endmodule

// File: design/scale_coef_regs.sv
module scale_coef_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    coef_we,
    input  requant_pkg::chan_t      coef_addr,
    input  requant_pkg::coef_t      coef_wdata,
    input  requant_pkg::chan_t      rd_chan [requant_pkg::NUM_LANES],
    output requant_pkg::coef_t [1:0] rd_pair [requant_pkg::NUM_LANES]
);
    import requant_pkg::*;

    // unity scale, no bias, no shift
    localparam coef_t COEF_RESET = '{bias: '0, tail: 16'd1, rank: '0};

    coef_t coef_tbl [NUM_CHANNELS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                coef_tbl[c] <= COEF_RESET;
            end
        end else if (coef_we) begin
            coef_tbl[coef_addr] <= coef_wdata;
        end
    end

    // each lane sees ch and ch+1 of its head word
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_rd
        assign rd_pair[l][0] = coef_tbl[rd_chan[l]];
        assign rd_pair[l][1] = coef_tbl[chan_t'(rd_chan[l] + 1'b1)];
    end

endmodule

// File: design/scale_mult_array.sv
module scale_mult_array (
    input  logic                     clk,
    input  logic                     reset,
    mult_port_if.arb                 port,
    input  num_fmt_pkg::tail_t [1:0] tail_pair
);
    import num_fmt_pkg::*;

    logic signed [40:0] mul_full [2];
    prod_t [1:0]        prod_q;
    logic               p_valid_q;

    assign port.gnt = port.req;  // never busy
    assign port.p_valid = p_valid_q;
    assign port.p_pair = prod_q;

    for (genvar h = 0; h < 2; h++) begin : g_mul
        // tail is unsigned, widen with a zero before the signed multiply
        assign mul_full[h] = $signed(port.a_pair[h]) * $signed({1'b0, tail_pair[h]});

        always_ff @(posedge clk) begin
            if (port.req) prod_q[h] <= prod_t'(mul_full[h]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) p_valid_q <= 1'b0;
        else p_valid_q <= port.req;
    end

endmodule

// File: filelist.f
design/num_fmt_pkg.sv
design/requant_pkg.sv
design/mult_port_if.sv
design/credit_fifo.sv
design/scale_coef_regs.sv
design/requant_lane.sv
design/mult_arbiter.sv
design/scale_mult_array.sv
design/requant_top.sv
tests/requant_sva.sv
tests/requant_tb.sv

// File: tests/requant_sva.sv
module requant_sva (
    input logic                          clk,
    input logic                          reset,
    input logic [requant_pkg::NUM_LANES-1:0] req_vec,
    input logic [requant_pkg::NUM_LANES-1:0] gnt_vec
);
    import requant_pkg::*;

    int fail_count = 0;  // read by the testbench at the end of the run

    // one lane owns the shared multiplier per cycle
    one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(gnt_vec))
        else begin
            fail_count++;
            $error("more than one lane granted in one cycle");
        end

    no_idle_grant: assert property (@(posedge clk) disable iff (reset)
        (gnt_vec & ~req_vec) == '0)
        else begin
            fail_count++;
            $error("grant given to a lane that does not request");
        end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_hold
        req_hold: assert property (@(posedge clk) disable iff (reset)
            req_vec[i] && !gnt_vec[i] |=> req_vec[i])
            else begin
                fail_count++;
                $error("lane %0d dropped its request before grant", i);
            end
    end

endmodule

// File: tests/requant_tb.sv
module requant_tb;
    import num_fmt_pkg::*;
    import requant_pkg::*;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;
    localparam int N_SINGLE    = 24;  // mode_88, lane 0 only
    localparam int N_RANDOM    = 40;  // per lane from here on
    localparam int N_HELD      = 10;
    localparam int N_RELOAD    = 30;
    localparam int TOTAL_WORDS = N_SINGLE + NUM_LANES * (N_RANDOM + N_HELD + N_RELOAD);
    localparam int HOLD_CYCLES = 80;

    typedef struct {
        acc_word_u word;
        chan_t     chan;
        int        gap;
    } stim_t;

    logic                      clk;
    logic                      reset;
    mode_e                     mode;
    logic                      coef_we;
    chan_t                     coef_addr;
    coef_t                     coef_wdata;
    logic [NUM_LANES-1:0]      in_valid;
    acc_word_u [NUM_LANES-1:0] in_word;
    chan_t [NUM_LANES-1:0]     in_chan;
    logic [NUM_LANES-1:0]      in_credit;
    logic [NUM_LANES-1:0]      out_valid;
    out_word_t [NUM_LANES-1:0] out_data;
    logic [NUM_LANES-1:0]      out_credit;

    int        seed = 32'h80ea_e2b2;
    coef_t     coef_model [NUM_CHANNELS];
    stim_t     stim_q [NUM_LANES][$];
    out_word_t exp_q [NUM_LANES][$];
    int        src_credits [NUM_LANES];
    int        sent [NUM_LANES];
    int        returned [NUM_LANES];
    int        sink_credits [NUM_LANES];  // DUT output credits as the sink sees them
    int        owed [NUM_LANES];          // credits the sink has yet to hand back
    int        held_outs [NUM_LANES];
    int        sat_max;
    int        sat_min;
    logic      hold_out;

    requant_top #(
        .IN_DEPTH   (IN_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .coef_we   (coef_we),
        .coef_addr (coef_addr),
        .coef_wdata(coef_wdata),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_chan   (in_chan),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_credit(out_credit)
    );

    bind mult_arbiter requant_sva u_sva (
        .clk    (clk),
        .reset  (reset),
        .req_vec(req_vec),
        .gnt_vec({lanes[1].gnt, lanes[0].gnt})
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic q8_t requant_half(longint v, coef_t c);
        longint s;
        longint p;
        s = v + longint'($signed(c.bias));
        s = longint'($signed(s[23:0]));  // sum_t width
        p = s * longint'(c.tail);
        if (c.rank != 0) begin
            p = (p + (longint'(1) << (c.rank - 1))) >>> c.rank;
        end
        if (p > 127) return 8'sh7f;
        if (p < -128) return 8'sh80;
        return q8_t'(p);
    endfunction

    function automatic out_word_t requant_ref(mode_e m, acc_word_u w, coef_t c0, coef_t c1);
        out_word_t r;
        if (m == mode_88) begin
            r.b0 = requant_half(longint'(w.full), c0);
            r.b1 = '0;
        end else begin
            r.b0 = requant_half(longint'(w.half.lo), c0);
            r.b1 = requant_half(longint'(w.half.hi), c1);
        end
        return r;
    endfunction

    task automatic fail_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_out(string name, out_word_t got, out_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_coefs(bit for_limits);
        coef_t c;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            c.bias = 8'($random(seed));
            c.tail = 16'($random(seed));
            if (for_limits) begin
                c.tail[15] = 1'b1;  // large tail, small rank
                c.rank = 5'(16 + {$random(seed)} % 8);
            end else begin
                c.rank = 5'($random(seed));
            end
            @(negedge clk);
            coef_we = 1'b1;
            coef_addr = chan_t'(ch);
            coef_wdata = c;
            coef_model[ch] = c;
        end
        @(negedge clk);
        coef_we = 1'b0;
    endtask

    task automatic queue_words(int lane, int n, int gap_max, bit with_limits);
        stim_t s;
        for (int k = 0; k < n; k++) begin
            s.chan = chan_t'($random(seed));
            if (mode == mode_18) begin
                s.chan[0] = 1'b0;  // pair starts on an even channel
                s.word.half.lo = 16'($random(seed));
                s.word.half.hi = 16'($random(seed));
            end else if (with_limits && k < 2) begin
                s.word.full = (k == 0) ? 32'sd4194048 : -32'sd4194048;  // near 2**22
            end else begin
                s.word.full = $random(seed) % 32'sd1048576;
            end
            s.gap = {$random(seed)} % (gap_max + 1);
            stim_q[lane].push_back(s);
            exp_q[lane].push_back(requant_ref(mode, s.word, coef_model[s.chan],
                                              coef_model[chan_t'(s.chan + 1)]));
        end
    endtask

    // starts and ends on a falling edge
    task automatic drive_lane(int lane);
        stim_t s;
        while (stim_q[lane].size() != 0) begin
            s = stim_q[lane].pop_front();
            repeat (s.gap) @(negedge clk);
            while (src_credits[lane] == 0) @(negedge clk);
            in_valid[lane] = 1'b1;
            in_word[lane] = s.word;
            in_chan[lane] = s.chan;
            src_credits[lane]--;
            sent[lane]++;
            @(negedge clk);
            in_valid[lane] = 1'b0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || owed[0] != 0 || owed[1] != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_count($sformatf("in_credit pulses, lane %0d", l), returned[l], sent[l]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // clock, sink, monitor and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (!reset && !hold_out && owed[l] > 0) begin
                out_credit[l] = 1'b1;
                owed[l]--;
            end else begin
                out_credit[l] = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (!reset) begin
                if (in_credit[l]) begin
                    src_credits[l]++;
                    returned[l]++;
                end
                if (src_credits[l] > IN_DEPTH) begin
                    $display("lane %0d returned more input credits than words sent", l);
                    fail_run();
                end
                if (out_credit[l]) sink_credits[l]++;
                if (out_valid[l]) begin
                    if (sink_credits[l] == 0) begin
                        $display("lane %0d raised out_valid without an output credit", l);
                        fail_run();
                    end
                    if (exp_q[l].size() == 0) begin
                        $display("lane %0d produced a word that was never sent", l);
                        fail_run();
                    end
                    check_out($sformatf("out_data[%0d]", l), out_data[l], exp_q[l].pop_front());
                    sink_credits[l]--;
                    owed[l]++;
                    if (hold_out) held_outs[l]++;
                    if (out_data[l].b0 == 8'sh7f) sat_max++;
                    if (out_data[l].b0 == 8'sh80) sat_min++;
                end
            end
        end
    end

    initial begin
        repeat (200 * TOTAL_WORDS) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", 200 * TOTAL_WORDS);
        fail_run();
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        mode = mode_88;
        coef_we = 1'b0;
        coef_addr = '0;
        coef_wdata = '0;
        in_valid = '0;
        in_word = '0;
        in_chan = '0;
        out_credit = '0;
        hold_out = 1'b0;
        sat_max = 0;
        sat_min = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            src_credits[l] = IN_DEPTH;
            sink_credits[l] = OUT_CREDITS;
            sent[l] = 0;
            returned[l] = 0;
            owed[l] = 0;
            held_outs[l] = 0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        repeat (5) begin
            @(posedge clk);
            check_count("out_valid after reset", int'(out_valid), 0);
            check_count("in_credit after reset", int'(in_credit), 0);
        end

        load_coefs(1'b1);  // mode_88 on lane 0, both limits
        queue_words(0, N_SINGLE, 2, 1'b1);
        drive_lane(0);
        wait_drain();
        check_count("results at +127", int'(sat_max != 0), 1);
        check_count("results at -128", int'(sat_min != 0), 1);

        mode = mode_18;
        load_coefs(1'b0);
        queue_words(0, N_RANDOM, 3, 1'b0);
        queue_words(1, N_RANDOM, 3, 1'b0);
        fork
            drive_lane(0);
            drive_lane(1);
        join
        wait_drain();

        hold_out = 1'b1;  // sink keeps its credits
        queue_words(0, N_HELD, 0, 1'b0);
        queue_words(1, N_HELD, 0, 1'b0);
        fork
            begin
                fork
                    drive_lane(0);
                    drive_lane(1);
                join
            end
            begin
                repeat (HOLD_CYCLES) @(posedge clk);
                for (int l = 0; l < NUM_LANES; l++) begin
                    check_count($sformatf("out_valid while held, lane %0d", l),
                                held_outs[l], OUT_CREDITS);
                end
                @(negedge clk);
                hold_out = 1'b0;
            end
        join
        wait_drain();

        load_coefs(1'b0);  // new table between batches
        queue_words(0, N_RELOAD, 1, 1'b0);
        queue_words(1, N_RELOAD, 1, 1'b0);
        fork
            drive_lane(0);
            drive_lane(1);
        join
        wait_drain();

        if (i_dut.u_arb.u_sva.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("arbiter assertions failed %0d times", i_dut.u_arb.u_sva.fail_count);
            fail_run();
        end
    end

endmodule
